// File: joyport_top.f
+incdir+common
+incdir+verif
common/joyport_pkg.sv
logic/port_scanner.sv
logic/pad_encoder.sv
logic/mouse_tracker.sv
logic/joyport_top.sv
verif/joyport_tb.sv

// File: Bender.yml
package:
  name: joyport

sources:
  - include_dirs:
      - common
    files:
      - common/joyport_pkg.sv
      - logic/port_scanner.sv
      - logic/pad_encoder.sv
      - logic/mouse_tracker.sv
      - logic/joyport_top.sv
  - target: test
    include_dirs:
      - common
      - verif
    files:
      - verif/joyport_tb.sv

// File: verif/joyport_tb_cases.svh
//////////////////////////////////////////////////////////////////////
// Controller port case table
// Columns are name, cfg {multitap, six button, mouse}, sel, clr,
// mouse action, expected from the model, fixed expected nibble
//////////////////////////////////////////////////////////////////////

// Mouse readout straight after reset, phase starts at Y_LOW
add_case("m_sample", 3'b001, 1'b0, 1'b0, MS_FIXED, 1'b1, 4'h0);
add_case("m_clr1", 3'b001, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("m_x_high", 3'b001, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("m_clr2", 3'b001, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("m_x_low", 3'b001, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("m_clr3", 3'b001, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("m_y_high", 3'b001, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("m_clr4", 3'b001, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("m_y_low", 3'b001, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("m_clr5", 3'b001, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("m_zero", 3'b001, 1'b1, 1'b0, MS_NONE, 1'b0, 4'h0);
add_case("m_clr6", 3'b001, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("m_mid", 3'b001, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("m_new", 3'b001, 1'b1, 1'b0, MS_RANDOM, 1'b1, 4'h0);
// Console stops polling halfway through a readout
add_case("m_idle", 3'b001, 1'b1, 1'b0, MS_IDLE, 1'b1, 4'h0);
add_case("m_clr7", 3'b001, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("m_fresh", 3'b001, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);

// Single pad, sel rise without multitap stays on pad 0
add_case("pad_clr", 3'b000, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("pad_dir", 3'b000, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("pad_btn", 3'b000, 1'b0, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("pad_same", 3'b000, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);

// Multitap walk to the first empty port
add_case("tap_clr", 3'b100, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("tap_p0_lo", 3'b100, 1'b0, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("tap_p1_hi", 3'b100, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("tap_p1_lo", 3'b100, 1'b0, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("tap_p2_hi", 3'b100, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("tap_p2_lo", 3'b100, 1'b0, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("tap_p3_hi", 3'b100, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("tap_p3_lo", 3'b100, 1'b0, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("tap_p4_hi", 3'b100, 1'b1, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("tap_p4_lo", 3'b100, 1'b0, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("tap_p5_hi", 3'b100, 1'b1, 1'b0, MS_NONE, 1'b0, 4'hF);
add_case("tap_p5_lo", 3'b100, 1'b0, 1'b0, MS_NONE, 1'b0, 4'hF);

// Six-button bank, then the same clear with the bank disabled
add_case("six_clr", 3'b010, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("six_bank", 3'b010, 1'b0, 1'b0, MS_NONE, 1'b1, 4'h0);
add_case("six_bank_hi", 3'b010, 1'b1, 1'b0, MS_NONE, 1'b0, 4'h0);
add_case("nosix_clr", 3'b000, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("nosix_lo", 3'b000, 1'b0, 1'b0, MS_NONE, 1'b1, 4'h0);

// Clear held high
add_case("clr_hold", 3'b000, 1'b0, 1'b1, MS_NONE, 1'b0, 4'h0);
add_case("clr_hold_sel", 3'b000, 1'b1, 1'b1, MS_NONE, 1'b0, 4'h0);

// File: verif/joyport_tb.sv
//////////////////////////////////////////////////////////////////////
// Controller port testbench
// Clock and reset, xorshift pad words, reference model of the port
// encoding, case table loop, value check and cycle timeout
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "joyport_params.svh"

module joyport_tb;

	localparam int RESET_CYCLES = 16;
	localparam int ROW_CYCLES = 3;
	localparam int IDLE_CYCLES = 33000;
	localparam int MAX_CASES = 64;

	// Mouse action per table row
	localparam logic [1:0] MS_NONE = 2'd0;
	localparam logic [1:0] MS_FIXED = 2'd1;
	localparam logic [1:0] MS_RANDOM = 2'd2;
	localparam logic [1:0] MS_IDLE = 2'd3;

	typedef struct packed {
		joyport_pkg::joyport_cfg_t cfg;
		logic sel;
		logic clr;
		logic [1:0] action;
		logic use_model;
		joyport_pkg::nibble_t expected;
	} case_row_t;

	logic clk_sys;
	logic reset;
	joyport_pkg::port_ctl_t port_ctl;
	joyport_pkg::joyport_cfg_t cfg;
	joyport_pkg::pad_array_t pads;
	joyport_pkg::mouse_sample_t mouse;
	joyport_pkg::nibble_t nibble_out;

	string case_name [MAX_CASES];
	case_row_t cases [MAX_CASES];
	int num_cases;
	int num_idle;
	int errors;
	int cycle_cnt;
	int timeout_limit;
	logic [31:0] rng;

	// Reference model state
	logic [2:0] m_idx;
	logic m_bank;
	logic [1:0] m_phase;
	logic [7:0] m_raw_x;
	logic [7:0] m_raw_y;
	logic [7:0] m_out_x;
	logic [7:0] m_out_y;
	logic m_sel;
	logic m_clr;

	joyport_top uut (
		.clk_sys(clk_sys),
		.reset(reset),
		.port_ctl(port_ctl),
		.cfg(cfg),
		.pads(pads),
		.mouse(mouse),
		.nibble_out(nibble_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_limit) begin
			$display("Timeout: the case table did not finish within %0d cycles", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string name, input logic [3:0] expected,
		input logic [3:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic add_case(input string name, input logic [2:0] row_cfg, input logic sel,
		input logic clr, input logic [1:0] action, input logic use_model,
		input logic [3:0] expected);
		case_name[num_cases] = name;
		cases[num_cases] = {row_cfg, sel, clr, action, use_model, expected};
		if (action == MS_IDLE) begin
			num_idle++;
		end
		num_cases++;
	endtask

	task automatic load_cases();
		`include "joyport_tb_cases.svh"
	endtask

	//////////////////////////////////////////////////////////////////////
	// Port data from the encoding rule
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] model_port_data(input logic [2:0] idx, input logic mouse_en);
		logic [11:0] p;
		logic [3:0] mouse_nib;
		logic [7:0] mouse_byte;
		logic [3:0] buttons;
		logic [3:0] dirs;
		logic [3:0] extra;
		case (m_phase)
			2'd0: mouse_nib = m_out_x[7:4];
			2'd1: mouse_nib = m_out_x[3:0];
			2'd2: mouse_nib = m_out_y[7:4];
			default: mouse_nib = m_out_y[3:0];
		endcase
		if (mouse_en && idx == 3'd0) begin
			p = pads[0];
			mouse_byte = {mouse_nib, ~p[7], ~p[6], ~mouse.btn_left, ~mouse.btn_right};
			return {mouse_byte, mouse_byte};
		end
		if (idx >= `JOYPORT_NUM_PADS) begin
			return 16'h0FFF;
		end
		p = pads[idx];
		// Button I at bit 0 up to run at bit 3
		buttons[0] = p[4];
		buttons[1] = p[5];
		buttons[2] = p[6];
		buttons[3] = p[7];
		// Up, right, down, left from bit 0
		dirs[0] = p[3];
		dirs[1] = p[0];
		dirs[2] = p[2];
		dirs[3] = p[1];
		extra = p[11:8];
		return {4'h0, ~extra, ~dirs, ~buttons};
	endfunction

	// Entered 2 ns after a rising edge
	task automatic run_case(input int n);
		case_row_t row;
		logic [31:0] sample;
		logic [15:0] data;
		logic [3:0] expected;
		row = cases[n];
		if (row.action == MS_FIXED || row.action == MS_RANDOM) begin
			rng = next_random(rng);
			sample = (row.action == MS_FIXED) ? 32'h0001_A713 : rng;
			mouse.dx = sample[7:0];
			mouse.dy = sample[15:8];
			mouse.btn_left = sample[16];
			mouse.btn_right = sample[17];
			mouse.strobe = ~mouse.strobe;
			m_raw_x = 8'd0 - sample[7:0];
			m_raw_y = sample[15:8];
		end
		cfg = row.cfg;
		port_ctl.sel = row.sel;
		port_ctl.clr = row.clr;
		// Clear edge steps the bank and the mouse phase
		if (row.clr && !m_clr) begin
			m_bank = ~m_bank & row.cfg.six_button_en;
			if (m_phase == 2'd3) begin
				m_out_x = m_raw_x;
				m_out_y = m_raw_y;
				m_raw_x = '0;
				m_raw_y = '0;
			end
			m_phase = m_phase + 2'd1;
		end
		if (row.clr) begin
			m_idx = '0;
		end else if (row.sel && !m_sel && row.cfg.multitap_en) begin
			m_idx = m_idx + 3'd1;
		end
		m_sel = row.sel;
		m_clr = row.clr;
		if (row.action == MS_IDLE) begin
			repeat (IDLE_CYCLES) @(posedge clk_sys);
			m_phase = 2'd3;
		end
		repeat (ROW_CYCLES) @(posedge clk_sys);
		#2;
		data = model_port_data(m_idx, row.cfg.mouse_en);
		expected = row.clr ? 4'h0 : data[{m_bank, row.sel, 2'b00} +: 4];
		if (!row.use_model) begin
			expected = row.expected;
		end
		check_value(case_name[n], expected, nibble_out);
	endtask

	initial begin
		errors = 0;
		cycle_cnt = 0;
		num_cases = 0;
		num_idle = 0;
		rng = 32'd68798;
		reset = 1'b1;
		port_ctl = '0;
		cfg = '0;
		mouse = '0;
		for (int i = 0; i < `JOYPORT_NUM_PADS; i++) begin
			rng = next_random(rng);
			pads[i] = rng[11:0];
		end
		m_idx = '0;
		m_bank = 1'b0;
		m_phase = 2'd3;
		m_raw_x = '0;
		m_raw_y = '0;
		m_out_x = '0;
		m_out_y = '0;
		m_sel = 1'b0;
		m_clr = 1'b0;
		load_cases();
		// Reset, every row and every idle wait, with half again as margin
		timeout_limit = (RESET_CYCLES + num_cases * ROW_CYCLES + num_idle * IDLE_CYCLES) * 3 / 2;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		for (int n = 0; n < num_cases; n++) begin
			run_case(n);
		end
		$display("Cases: %0d, errors: %0d", num_cases, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: logic/joyport_top.sv
//////////////////////////////////////////////////////////////////////
// Controller port top level
// Port scanner, pad encoder and mouse tracker, wired together
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module joyport_top (
	input logic clk_sys,
	input logic reset,
	input joyport_pkg::port_ctl_t port_ctl,
	input joyport_pkg::joyport_cfg_t cfg,
	input joyport_pkg::pad_array_t pads,
	input joyport_pkg::mouse_sample_t mouse,
	output joyport_pkg::nibble_t nibble_out
);

	joyport_pkg::port_idx_t port_idx;
	joyport_pkg::pad_data_t pad_data;
	joyport_pkg::nibble_t mouse_nibble;
	logic clr_rise;

	// Console side sequencing and output latch
	// Bank flag is consumed inside the scanner itself
	port_scanner u_port_scanner (
		.clk_sys(clk_sys),
		.reset(reset),
		.port_ctl(port_ctl),
		.multitap_en(cfg.multitap_en),
		.six_button_en(cfg.six_button_en),
		.pad_data(pad_data),
		.port_idx(port_idx),
		.high_bank(),
		.clr_rise(clr_rise),
		.nibble_out(nibble_out)
	);

	// Pad word to port data
	pad_encoder u_pad_encoder (
		.pads(pads),
		.mouse_en(cfg.mouse_en),
		.btn_left(mouse.btn_left),
		.btn_right(mouse.btn_right),
		.port_idx(port_idx),
		.mouse_nibble(mouse_nibble),
		.pad_data(pad_data)
	);

	// Mouse deltas, read out a nibble per clear edge
	mouse_tracker u_mouse_tracker (
		.clk_sys(clk_sys),
		.reset(reset),
		.clr(port_ctl.clr),
		.clr_rise(clr_rise),
		.strobe(mouse.strobe),
		.dx(mouse.dx),
		.dy(mouse.dy),
		.mouse_nibble(mouse_nibble)
	);

endmodule

// File: logic/mouse_tracker.sv
//////////////////////////////////////////////////////////////////////
// Mouse tracker
// Sample capture on strobe toggle, four-phase delta readout stepped
// by clear edges, idle timeout back to the last phase
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "joyport_params.svh"

module mouse_tracker (
	input logic clk_sys,
	input logic reset,
	input logic clr,
	input logic clr_rise,
	input logic strobe,
	input joyport_pkg::mouse_delta_t dx,
	input joyport_pkg::mouse_delta_t dy,
	output joyport_pkg::nibble_t mouse_nibble
);

	logic strobe_q;
	logic new_sample;
	logic idle_sat;
	logic [`JOYPORT_MOUSE_TO_W-1:0] idle_cnt;
	joyport_pkg::mouse_delta_t raw_x;
	joyport_pkg::mouse_delta_t raw_y;
	joyport_pkg::mouse_delta_t out_x;
	joyport_pkg::mouse_delta_t out_y;
	joyport_pkg::mouse_phase_e phase;
	joyport_pkg::mouse_phase_e next_phase;

	assign new_sample = strobe ^ strobe_q;
	assign idle_sat = &idle_cnt;
	assign next_phase = joyport_pkg::mouse_phase_e'(phase + 2'd1);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe_q <= 1'b0;
			idle_cnt <= '0;
			raw_x <= '0;
			raw_y <= '0;
			out_x <= '0;
			out_y <= '0;
			phase <= joyport_pkg::Y_LOW;
		end else begin
			strobe_q <= strobe;

			// Counts only while the console leaves clear low
			if (clr) begin
				idle_cnt <= '0;
			end else if (!idle_sat) begin
				idle_cnt <= idle_cnt + 1'b1;
			end
			if (idle_sat) begin
				phase <= joyport_pkg::Y_LOW;
			end

			if (clr_rise) begin
				phase <= next_phase;
				// Start of a new read, hand over accumulated deltas
				if (phase == joyport_pkg::Y_LOW) begin
					out_x <= raw_x;
					out_y <= raw_y;
					raw_x <= '0;
					raw_y <= '0;
				end
			end

			// X is reported negated
			if (new_sample) begin
				raw_x <= 8'd0 - dx;
				raw_y <= dy;
			end
		end
	end

	always_comb begin
		case (phase)
			joyport_pkg::X_HIGH: mouse_nibble = out_x[7:4];
			joyport_pkg::X_LOW: mouse_nibble = out_x[3:0];
			joyport_pkg::Y_HIGH: mouse_nibble = out_y[7:4];
			default: mouse_nibble = out_y[3:0];
		endcase
	end

	// Clear rise always follows a clear level, so timeout and step never meet
	a_idle_phase: assert property (@(posedge clk_sys) disable iff (reset)
		idle_sat |=> phase == joyport_pkg::Y_LOW);

endmodule

// File: logic/pad_encoder.sv
//////////////////////////////////////////////////////////////////////
// Pad encoder
// Picks the pad word for the current port, reorders it into the
// active-low port layout, substitutes the mouse byte on port 0
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "joyport_params.svh"

module pad_encoder (
	input joyport_pkg::pad_array_t pads,
	input logic mouse_en,
	input logic btn_left,
	input logic btn_right,
	input joyport_pkg::port_idx_t port_idx,
	input joyport_pkg::nibble_t mouse_nibble,
	output joyport_pkg::pad_data_t pad_data
);

	joyport_pkg::pad_word_t pad_sel;
	logic [7:0] mouse_byte;
	logic idx_valid;
	logic mouse_port;

	assign idx_valid = int'(port_idx) < `JOYPORT_NUM_PADS;
	assign mouse_port = mouse_en && (port_idx == '0);

	// Pad word for the current port
	always_comb begin
		pad_sel = '0;
		for (int i = 0; i < `JOYPORT_NUM_PADS; i++) begin
			if (int'(port_idx) == i) begin
				pad_sel = pads[i];
			end
		end
	end

	// Low nibble is run, select, left, right of pad 0 and the mouse
	assign mouse_byte = {mouse_nibble, ~{pads[0][7], pads[0][6], btn_left, btn_right}};

	//////////////////////////////////////////////////////////////////////
	// Port data
	//////////////////////////////////////////////////////////////////////

	// Nibble 0 buttons I II select run
	// Nibble 1 up right down left
	// Nibble 2 buttons III to VI, nibble 3 unused and reads as zero
	always_comb begin
		if (mouse_port) begin
			pad_data = {mouse_byte, mouse_byte};
		end else if (idx_valid) begin
			pad_data = ~{4'hF, pad_sel[11:8],
				pad_sel[1], pad_sel[2], pad_sel[0], pad_sel[3],
				pad_sel[7:4]};
		end else begin
			pad_data = `JOYPORT_IDLE_DATA;
		end
	end

endmodule

// File: logic/port_scanner.sv
//////////////////////////////////////////////////////////////////////
// Port scanner
// Edge detect on the console sel and clr lines, multitap port index,
// six-button bank flag and the registered output nibble
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module port_scanner (
	input logic clk_sys,
	input logic reset,
	input joyport_pkg::port_ctl_t port_ctl,
	input logic multitap_en,
	input logic six_button_en,
	input joyport_pkg::pad_data_t pad_data,
	output joyport_pkg::port_idx_t port_idx,
	output logic high_bank,
	output logic clr_rise,
	output joyport_pkg::nibble_t nibble_out
);

	joyport_pkg::port_ctl_t ctl_q;
	logic clr_edge;
	logic sel_edge;

	assign clr_edge = port_ctl.clr & ~ctl_q.clr;
	assign sel_edge = port_ctl.sel & ~ctl_q.sel;

	// Clear wins over the select advance
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctl_q <= '0;
			port_idx <= '0;
			high_bank <= 1'b0;
			clr_rise <= 1'b0;
			nibble_out <= '0;
		end else begin
			ctl_q <= port_ctl;
			clr_rise <= clr_edge;
			nibble_out <= pad_data[{high_bank, port_ctl.sel, 2'b00} +: 4];
			if (port_ctl.clr) begin
				port_idx <= '0;
				nibble_out <= '0;
				// Bank toggles once per clear pulse
				if (clr_edge) begin
					high_bank <= ~high_bank & six_button_en;
				end
			end else if (sel_edge && multitap_en) begin
				// Wraps at eight, ports past the pads read empty
				port_idx <= port_idx + 3'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	a_clr_zero: assert property (@(posedge clk_sys) disable iff (reset)
		port_ctl.clr |=> nibble_out == '0);

	a_clr_rise_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		clr_rise |=> !clr_rise);

	// High bank only with six buttons enabled
	a_bank_gated: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(high_bank) |-> $past(six_button_en));

endmodule

// File: common/joyport_pkg.sv
//////////////////////////////////////////////////////////////////////
// Controller port types
// Pad words, port data and nibble vectors, port line and config
// structs, mouse sample struct and the mouse readout phase
//////////////////////////////////////////////////////////////////////

`include "joyport_params.svh"

package joyport_pkg;

	// Active-high pad bits
	// 0..3 right left down up, 4..7 I II select run, 8..11 III..VI
	typedef logic [`JOYPORT_PAD_W-1:0] pad_word_t;
	typedef pad_word_t [`JOYPORT_NUM_PADS-1:0] pad_array_t;

	// Four active-low nibbles, indexed by {high bank, sel}
	typedef logic [15:0] pad_data_t;
	typedef logic [3:0] nibble_t;
	typedef logic [2:0] port_idx_t;
	typedef logic [7:0] mouse_delta_t;

	// Console port lines
	typedef struct packed {
		logic clr;
		logic sel;
	} port_ctl_t;

	typedef struct packed {
		logic multitap_en;
		logic six_button_en;
		logic mouse_en;
	} joyport_cfg_t;

	// New sample whenever strobe toggles
	typedef struct packed {
		logic strobe;
		logic btn_left;
		logic btn_right;
		mouse_delta_t dx;
		mouse_delta_t dy;
	} mouse_sample_t;

	typedef enum logic [1:0] {
		X_HIGH = 2'd0,
		X_LOW = 2'd1,
		Y_HIGH = 2'd2,
		Y_LOW = 2'd3
	} mouse_phase_e;

endpackage

// File: common/joyport_params.svh
//////////////////////////////////////////////////////////////////////
// Controller port build constants
// Multitap pad count, pad word width, mouse idle counter width
// and the data returned for ports past the last pad
//////////////////////////////////////////////////////////////////////

`ifndef JOYPORT_PARAMS_SVH
`define JOYPORT_PARAMS_SVH

// Gamepads behind the multitap
`define JOYPORT_NUM_PADS 5

// One gamepad word
// Directions, four base buttons, four extra buttons
`define JOYPORT_PAD_W 12

// Mouse idle counter
// Phase returns to Y_LOW after 32767 cycles without clear
`define JOYPORT_MOUSE_TO_W 15

// Empty port
// Low twelve bits read as released, top nibble reads as pressed
`define JOYPORT_IDLE_DATA 16'h0FFF

`endif
